// ==== source/z80_pkg.sv ====
package z80_pkg;

    parameter int addr_width = 16;
    parameter int data_width = 8;

    // Execution groups of the unprefixed load, exchange and stack instructions.
    typedef enum logic [4:0] {
        grp_nop,
        grp_ld_r_r,
        grp_ld_r_n,
        grp_ld_r_ind_hl,
        grp_ld_ind_hl_r,
        grp_ld_ind_hl_n,
        grp_ld_dd_nn,
        grp_ld_a_ind_nn,
        grp_ld_ind_nn_a,
        grp_ld_a_ind_bcde,
        grp_ld_ind_bcde_a,
        grp_ld_hl_ind_nn,
        grp_ld_ind_nn_hl,
        grp_ld_sp_hl,
        grp_push_qq,
        grp_pop_qq,
        grp_ex_de_hl
    } insn_group_t;

    // Byte selects match the r field of the opcode, F takes the (HL) slot.
    typedef enum logic [3:0] {
        reg_b  = 4'd0,
        reg_c  = 4'd1,
        reg_d  = 4'd2,
        reg_e  = 4'd3,
        reg_h  = 4'd4,
        reg_l  = 4'd5,
        reg_f  = 4'd6,
        reg_a  = 4'd7,
        reg_bc = 4'd8,
        reg_de = 4'd9,
        reg_hl = 4'd10,
        reg_sp = 4'd11,
        reg_af = 4'd12
    } reg_sel_t;

    typedef enum logic [1:0] {
        st_exec,
        st_step1,
        st_step2,
        st_step3
    } seq_state_t;

endpackage

// ==== source/instr_decoder.sv ====
module instr_decoder import z80_pkg::*; (
    input  logic [data_width-1:0] opcode,
    output insn_group_t           group,
    output logic [1:0]            len
);

    logic [1:0] x;
    logic [2:0] y;
    logic [2:0] z;
    logic [1:0] p;
    logic       q;

    assign x = opcode[7:6];
    assign y = opcode[5:3];
    assign z = opcode[2:0];
    assign p = opcode[5:4];
    assign q = opcode[3];

    // Anything not listed below retires as a one-byte NOP, HALT included.
    always_comb begin
        group = grp_nop;
        len   = 2'd1;
        case (x)
            2'd0: begin
                if (z == 3'd1 && !q) begin
                    group = grp_ld_dd_nn;
                    len   = 2'd3;
                end else if (z == 3'd2 && !p[1]) begin
                    if (q)
                        group = grp_ld_a_ind_bcde;
                    else
                        group = grp_ld_ind_bcde_a;
                end else if (z == 3'd2) begin
                    len = 2'd3;
                    if (p[0] && q)
                        group = grp_ld_a_ind_nn;
                    else if (p[0])
                        group = grp_ld_ind_nn_a;
                    else if (q)
                        group = grp_ld_hl_ind_nn;
                    else
                        group = grp_ld_ind_nn_hl;
                end else if (z == 3'd6) begin
                    len = 2'd2;
                    if (y == 3'd6)
                        group = grp_ld_ind_hl_n;
                    else
                        group = grp_ld_r_n;
                end
            end
            2'd1: begin
                if (z == 3'd6 && y != 3'd6)
                    group = grp_ld_r_ind_hl;
                else if (y == 3'd6 && z != 3'd6)
                    group = grp_ld_ind_hl_r;
                else if (y != 3'd6)
                    group = grp_ld_r_r;
            end
            2'd3: begin
                if (z == 3'd1 && !q)
                    group = grp_pop_qq;
                else if (z == 3'd5 && !q)
                    group = grp_push_qq;
                else if (opcode == 8'hf9)
                    group = grp_ld_sp_hl;
                else if (opcode == 8'heb)
                    group = grp_ex_de_hl;
            end
            default: begin
                group = grp_nop;
            end
        endcase
    end

endmodule

// ==== source/insn_fetch.sv ====
module insn_fetch import z80_pkg::*; #(
    parameter logic [addr_width-1:0] reset_address = '0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [data_width-1:0]  mem_data,
    input  logic                   byte_take,
    input  logic                   retire,
    output logic [addr_width-1:0]  pc,
    output logic [data_width-1:0]  opcode,
    output logic [15:0]            operand,
    output insn_group_t            group,
    output logic                   insn_complete
);

    logic [1:0]            count;
    logic [1:0]            len;
    logic [data_width-1:0] byte0;
    logic [data_width-1:0] byte1;
    logic [data_width-1:0] byte2;

    // The byte at the current count comes straight from the bus.
    assign opcode         = (count == 2'd0) ? mem_data : byte0;
    assign operand[7:0]   = (count == 2'd1) ? mem_data : byte1;
    assign operand[15:8]  = (count == 2'd2) ? mem_data : byte2;

    // Counts the byte being taken in this cycle as already collected.
    assign insn_complete = ({1'b0, count} + {2'b00, byte_take}) == {1'b0, len};

    instr_decoder i_decoder (
        .opcode (opcode),
        .group  (group),
        .len    (len)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc    <= reset_address;
            count <= 2'd0;
        end else if (retire) begin
            count <= 2'd0;
        end else if (byte_take) begin
            pc    <= pc + 16'd1;
            count <= count + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (byte_take) begin
            case (count)
                2'd0: byte0 <= mem_data;
                2'd1: byte1 <= mem_data;
                default: byte2 <= mem_data;
            endcase
        end
    end

endmodule

// ==== source/register_file.sv ====
module register_file import z80_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  reg_sel_t    rd1_sel,
    input  reg_sel_t    rd2_sel,
    input  logic        wr_en,
    input  reg_sel_t    wr_sel,
    input  logic [15:0] wr_data,
    input  logic        ex_de_hl,
    output logic [15:0] rd1_data,
    output logic [15:0] rd2_data
);

    // B, C, D, E, H, L, F, A in r-field order.
    logic [7:0][data_width-1:0] regs;
    logic [15:0]                sp;

    function automatic logic [15:0] read_sel(
        input reg_sel_t                   sel,
        input logic [7:0][data_width-1:0] r,
        input logic [15:0]                s
    );
        case (sel)
            reg_bc: read_sel = {r[reg_b], r[reg_c]};
            reg_de: read_sel = {r[reg_d], r[reg_e]};
            reg_hl: read_sel = {r[reg_h], r[reg_l]};
            reg_sp: read_sel = s;
            reg_af: read_sel = {r[reg_a], r[reg_f]};
            default: read_sel = {8'h00, r[sel[2:0]]};
        endcase
    endfunction

    assign rd1_data = read_sel(rd1_sel, regs, sp);
    assign rd2_data = read_sel(rd2_sel, regs, sp);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs <= '0;
            sp   <= 16'h0000;
        end else if (ex_de_hl) begin
            regs[reg_d] <= regs[reg_h];
            regs[reg_e] <= regs[reg_l];
            regs[reg_h] <= regs[reg_d];
            regs[reg_l] <= regs[reg_e];
        end else if (wr_en) begin
            case (wr_sel)
                reg_bc: begin
                    regs[reg_b] <= wr_data[15:8];
                    regs[reg_c] <= wr_data[7:0];
                end
                reg_de: begin
                    regs[reg_d] <= wr_data[15:8];
                    regs[reg_e] <= wr_data[7:0];
                end
                reg_hl: begin
                    regs[reg_h] <= wr_data[15:8];
                    regs[reg_l] <= wr_data[7:0];
                end
                reg_sp: sp <= wr_data;
                reg_af: begin
                    regs[reg_a] <= wr_data[15:8];
                    regs[reg_f] <= wr_data[7:0];
                end
                default: regs[wr_sel[2:0]] <= wr_data[7:0];
            endcase
        end
    end

endmodule

// ==== source/sequencer.sv ====
module sequencer import z80_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [data_width-1:0] mem_data,
    input  logic [addr_width-1:0] pc,
    input  logic [data_width-1:0] opcode,
    input  logic [15:0]           operand,
    input  insn_group_t           group,
    input  logic                  insn_complete,
    input  logic [15:0]           rd1_data,
    input  logic [15:0]           rd2_data,
    output logic [addr_width-1:0] addr,
    output logic                  read_mem,
    output logic                  write_mem,
    output logic [data_width-1:0] write_data,
    output logic                  done,
    output logic                  byte_take,
    output reg_sel_t              rd1_sel,
    output reg_sel_t              rd2_sel,
    output logic                  wr_en,
    output reg_sel_t              wr_sel,
    output logic [15:0]           wr_data,
    output logic                  ex_de_hl
);

    seq_state_t            state;
    seq_state_t            next_state;
    logic [addr_width-1:0] data_addr;
    logic [addr_width-1:0] next_data_addr;
    logic [data_width-1:0] data_lo;
    logic [data_width-1:0] next_data_lo;
    logic [data_width-1:0] next_wdata;
    logic                  next_read;
    logic                  next_write;
    logic                  next_take;
    logic                  finish;
    reg_sel_t              src_sel;
    reg_sel_t              dst_sel;
    reg_sel_t              dd_sel;
    reg_sel_t              qq_sel;
    reg_sel_t              bcde_sel;
    logic                  two_byte_pop;

    // The bus shows pc in the fetch and retire cycles, else the data address.
    assign addr = (state == st_exec) ? pc : data_addr;

    assign src_sel      = reg_sel_t'({1'b0, opcode[2:0]});
    assign dst_sel      = reg_sel_t'({1'b0, opcode[5:3]});
    assign dd_sel       = reg_sel_t'({2'b10, opcode[5:4]});
    assign two_byte_pop = (group == grp_pop_qq);

    always_comb begin
        qq_sel   = dd_sel;
        bcde_sel = reg_bc;
        if (opcode[5:4] == 2'b11)
            qq_sel = reg_af;
        if (opcode[4])
            bcde_sel = reg_de;
    end

    always_comb begin
        next_state     = state;
        next_read      = 1'b0;
        next_write     = 1'b0;
        next_take      = 1'b0;
        next_data_addr = data_addr;
        next_wdata     = write_data;
        next_data_lo   = data_lo;
        rd1_sel        = reg_hl;
        rd2_sel        = reg_a;
        wr_en          = 1'b0;
        wr_sel         = dst_sel;
        wr_data        = rd1_data;
        ex_de_hl       = 1'b0;
        finish         = 1'b0;
        if (done || (state == st_exec && !insn_complete)) begin
            next_read = 1'b1;
            next_take = 1'b1;
        end else begin
            case (group)
                grp_ld_r_r: begin
                    rd1_sel = src_sel;
                    wr_en   = 1'b1;
                    finish  = 1'b1;
                end
                grp_ld_r_n: begin
                    wr_en   = 1'b1;
                    wr_data = {8'h00, operand[7:0]};
                    finish  = 1'b1;
                end
                grp_ld_dd_nn: begin
                    wr_en   = 1'b1;
                    wr_sel  = dd_sel;
                    wr_data = operand;
                    finish  = 1'b1;
                end
                grp_ld_sp_hl: begin
                    wr_en  = 1'b1;
                    wr_sel = reg_sp;
                    finish = 1'b1;
                end
                grp_ex_de_hl: begin
                    ex_de_hl = 1'b1;
                    finish   = 1'b1;
                end
                grp_ld_r_ind_hl, grp_ld_a_ind_nn, grp_ld_a_ind_bcde: begin
                    if (group == grp_ld_a_ind_bcde)
                        rd1_sel = bcde_sel;
                    if (state == st_exec) begin
                        next_data_addr = (group == grp_ld_a_ind_nn) ? operand : rd1_data;
                        next_read      = 1'b1;
                        next_state     = st_step1;
                    end else begin
                        wr_en   = 1'b1;
                        wr_data = {8'h00, mem_data};
                        finish  = 1'b1;
                        if (group != grp_ld_r_ind_hl)
                            wr_sel = reg_a;
                    end
                end
                grp_ld_ind_hl_r, grp_ld_ind_hl_n, grp_ld_ind_nn_a, grp_ld_ind_bcde_a: begin
                    if (group == grp_ld_ind_bcde_a)
                        rd1_sel = bcde_sel;
                    if (group == grp_ld_ind_hl_r)
                        rd2_sel = src_sel;
                    if (state == st_exec) begin
                        next_data_addr = (group == grp_ld_ind_nn_a) ? operand : rd1_data;
                        next_wdata = (group == grp_ld_ind_hl_n) ? operand[7:0] : rd2_data[7:0];
                        next_write = 1'b1;
                        next_state = st_step1;
                    end else begin
                        finish = 1'b1;
                    end
                end
                // Both read the low byte first and the high byte at the next address.
                grp_ld_hl_ind_nn, grp_pop_qq: begin
                    rd1_sel = two_byte_pop ? reg_sp : reg_hl;
                    case (state)
                        st_exec: begin
                            next_data_addr = two_byte_pop ? rd1_data : operand;
                            next_read      = 1'b1;
                            next_state     = st_step1;
                        end
                        st_step1: begin
                            next_data_lo   = mem_data;
                            next_data_addr = data_addr + 16'd1;
                            next_read      = 1'b1;
                            next_state     = st_step2;
                            wr_en          = two_byte_pop;
                            wr_sel         = reg_sp;
                            wr_data        = rd1_data + 16'd2;
                        end
                        default: begin
                            wr_en   = 1'b1;
                            wr_sel  = two_byte_pop ? qq_sel : reg_hl;
                            wr_data = {mem_data, data_lo};
                            finish  = 1'b1;
                        end
                    endcase
                end
                grp_ld_ind_nn_hl: begin
                    case (state)
                        st_exec: begin
                            next_data_addr = operand;
                            next_wdata     = rd1_data[7:0];
                            next_write     = 1'b1;
                            next_state     = st_step1;
                        end
                        st_step1: begin
                            next_data_addr = operand + 16'd1;
                            next_wdata     = rd1_data[15:8];
                            next_write     = 1'b1;
                            next_state     = st_step2;
                        end
                        default: finish = 1'b1;
                    endcase
                end
                grp_push_qq: begin
                    rd1_sel = reg_sp;
                    rd2_sel = qq_sel;
                    case (state)
                        st_exec: begin
                            next_data_addr = rd1_data - 16'd1;
                            next_wdata     = rd2_data[15:8];
                            next_write     = 1'b1;
                            next_state     = st_step1;
                        end
                        st_step1: begin
                            next_data_addr = rd1_data - 16'd2;
                            next_wdata     = rd2_data[7:0];
                            next_write     = 1'b1;
                            next_state     = st_step2;
                        end
                        default: begin
                            wr_en   = 1'b1;
                            wr_sel  = reg_sp;
                            wr_data = rd1_data - 16'd2;
                            finish  = 1'b1;
                        end
                    endcase
                end
                default: finish = 1'b1;
            endcase
        end
        if (finish) begin
            next_state = st_exec;
            next_read  = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= st_exec;
            read_mem  <= 1'b1;
            write_mem <= 1'b0;
            done      <= 1'b0;
            byte_take <= 1'b0;
        end else begin
            state     <= next_state;
            read_mem  <= next_read;
            write_mem <= next_write;
            done      <= finish;
            byte_take <= next_take;
        end
    end

    always_ff @(posedge clk) begin
        data_addr  <= next_data_addr;
        write_data <= next_wdata;
        data_lo    <= next_data_lo;
    end

endmodule

// ==== source/z80_core.sv ====
module z80_core import z80_pkg::*; #(
    parameter logic [addr_width-1:0] reset_address = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [data_width-1:0] mem_data,
    output logic [addr_width-1:0] addr,
    output logic                  read_mem,
    output logic                  write_mem,
    output logic [data_width-1:0] write_data,
    output logic                  done
);

    logic [addr_width-1:0] pc;
    logic [data_width-1:0] opcode;
    logic [15:0]           operand;
    insn_group_t           group;
    logic                  insn_complete;
    logic                  byte_take;
    reg_sel_t              rd1_sel;
    reg_sel_t              rd2_sel;
    reg_sel_t              wr_sel;
    logic [15:0]           rd1_data;
    logic [15:0]           rd2_data;
    logic [15:0]           wr_data;
    logic                  wr_en;
    logic                  ex_de_hl;

    insn_fetch #(
        .reset_address (reset_address)
    ) i_fetch (
        .clk           (clk),
        .reset         (reset),
        .mem_data      (mem_data),
        .byte_take     (byte_take),
        .retire        (done),
        .pc            (pc),
        .opcode        (opcode),
        .operand       (operand),
        .group         (group),
        .insn_complete (insn_complete)
    );

    sequencer i_sequencer (
        .clk           (clk),
        .reset         (reset),
        .mem_data      (mem_data),
        .pc            (pc),
        .opcode        (opcode),
        .operand       (operand),
        .group         (group),
        .insn_complete (insn_complete),
        .rd1_data      (rd1_data),
        .rd2_data      (rd2_data),
        .addr          (addr),
        .read_mem      (read_mem),
        .write_mem     (write_mem),
        .write_data    (write_data),
        .done          (done),
        .byte_take     (byte_take),
        .rd1_sel       (rd1_sel),
        .rd2_sel       (rd2_sel),
        .wr_en         (wr_en),
        .wr_sel        (wr_sel),
        .wr_data       (wr_data),
        .ex_de_hl      (ex_de_hl)
    );

    register_file i_regs (
        .clk      (clk),
        .reset    (reset),
        .rd1_sel  (rd1_sel),
        .rd2_sel  (rd2_sel),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data),
        .ex_de_hl (ex_de_hl),
        .rd1_data (rd1_data),
        .rd2_data (rd2_data)
    );

endmodule

// ==== verification/z80_core_sva.sv ====
module z80_core_sva import z80_pkg::*; #(
    parameter logic [addr_width-1:0] reset_address = '0
) (
    input logic                  clk,
    input logic                  reset,
    input logic [addr_width-1:0] addr,
    input logic                  read_mem,
    input logic                  write_mem,
    input logic                  done
);
    timeunit 1ns;
    timeprecision 100ps;

    no_read_write_overlap: assert property (@(posedge clk) disable iff (reset)
        !(read_mem && write_mem)) else $error("read_mem and write_mem high together");

    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        done |=> !done) else $error("done held for more than one cycle");

    fetch_after_done: assert property (@(posedge clk) disable iff (reset)
        done |=> read_mem) else $error("no read in the cycle after done");

    start_at_reset_address: assert property (@(posedge clk) disable iff (reset)
        $fell(reset) |-> addr == reset_address) else $error("first fetch address wrong");

endmodule

bind z80_core z80_core_sva #(
    .reset_address (reset_address)
) i_sva (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .read_mem  (read_mem),
    .write_mem (write_mem),
    .done      (done)
);

// ==== verification/z80_core_tb.sv ====
module z80_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        reset;
    logic [7:0]  mem_data;
    logic [15:0] addr;
    logic        read_mem;
    logic        write_mem;
    logic [7:0]  write_data;
    logic        done;

    logic [7:0]  mem [0:65535];
    logic [7:0]  ref_mem [0:65535];
    logic [7:0]  r [0:7];
    logic [15:0] sp;
    logic [15:0] mpc;
    logic [31:0] seed = 32'd98752;
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    int          n_insn = 0;
    int          done_count = 0;
    bit          gen_done = 0;

    z80_core #(
        .reset_address (16'h0000)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .mem_data   (mem_data),
        .addr       (addr),
        .read_mem   (read_mem),
        .write_mem  (write_mem),
        .write_data (write_data),
        .done       (done)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Byte-wide memory with combinational read.
    assign mem_data = mem[addr];
    always @(posedge clk) begin
        if (write_mem)
            mem[addr] <= write_data;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] expected);
        if (got !== expected)
            fail_run($sformatf("Fail %s: got %h expected %h", name, got, expected));
    endtask

    function automatic logic [15:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[30:15];
    endfunction

    function automatic logic [15:0] rand_addr();
        return 16'h8008 + (next_rand() % 16'h0ff0);
    endfunction

    function automatic logic [2:0] pick_reg();
        logic [15:0] v;
        v = next_rand();
        return (v[2:0] == 3'd6) ? 3'd7 : v[2:0];
    endfunction

    // One-byte opcodes that the core treats as no-operations.
    function automatic logic [7:0] nop_op(input logic [2:0] idx);
        case (idx)
            3'd0: return 8'h00;
            3'd1: return 8'h76;
            3'd2: return 8'h80;
            3'd3: return 8'hc3;
            3'd4: return 8'h3c;
            3'd5: return 8'hcb;
            3'd6: return 8'hed;
            default: return 8'hdd;
        endcase
    endfunction

    function automatic logic [15:0] get_pair(input logic [1:0] p, input bit qq);
        if (p == 2'd3)
            return qq ? {r[7], r[6]} : sp;
        return {r[{p, 1'b0}], r[{p, 1'b1}]};
    endfunction

    function automatic void set_pair(input logic [1:0] p, input bit qq, input logic [15:0] v);
        if (p == 2'd3 && qq) begin
            r[7] = v[15:8];
            r[6] = v[7:0];
        end else if (p == 2'd3) begin
            sp = v;
        end else begin
            r[{p, 1'b0}] = v[15:8];
            r[{p, 1'b1}] = v[7:0];
        end
    endfunction

    function automatic void model_write(input logic [15:0] a, input logic [7:0] d);
        ref_mem[a] = d;
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endfunction

    // Instruction-level interpreter of the Z80 loads, exchange and stack ops.
    function automatic void execute_model();
        logic [7:0]  op;
        logic [7:0]  n;
        logic [15:0] nn;
        logic [15:0] hl;
        logic [15:0] v;
        logic [2:0]  y;
        logic [2:0]  z;
        logic [1:0]  p;
        op = ref_mem[mpc];
        n  = ref_mem[mpc + 16'd1];
        nn = {ref_mem[mpc + 16'd2], n};
        y  = op[5:3];
        z  = op[2:0];
        p  = op[5:4];
        hl = get_pair(2'd2, 1'b0);
        mpc = mpc + 16'd1;
        if (op[7:6] == 2'd1 && op != 8'h76) begin
            if (y == 3'd6)
                model_write(hl, r[z]);
            else if (z == 3'd6)
                r[y] = ref_mem[hl];
            else
                r[y] = r[z];
        end else if (op[7:6] == 2'd0 && z == 3'd6) begin
            mpc = mpc + 16'd1;
            if (y == 3'd6)
                model_write(hl, n);
            else
                r[y] = n;
        end else if (op[7:6] == 2'd0 && z == 3'd1 && !op[3]) begin
            mpc = mpc + 16'd2;
            set_pair(p, 1'b0, nn);
        end else begin
            case (op)
                8'h02, 8'h12: model_write(get_pair(p, 1'b0), r[7]);
                8'h0a, 8'h1a: r[7] = ref_mem[get_pair(p, 1'b0)];
                8'h22: begin
                    mpc = mpc + 16'd2;
                    model_write(nn, hl[7:0]);
                    model_write(nn + 16'd1, hl[15:8]);
                end
                8'h2a: begin
                    mpc = mpc + 16'd2;
                    set_pair(2'd2, 1'b0, {ref_mem[nn + 16'd1], ref_mem[nn]});
                end
                8'h32: begin
                    mpc = mpc + 16'd2;
                    model_write(nn, r[7]);
                end
                8'h3a: begin
                    mpc = mpc + 16'd2;
                    r[7] = ref_mem[nn];
                end
                8'hf9: sp = hl;
                8'heb: begin
                    v = get_pair(2'd1, 1'b0);
                    set_pair(2'd1, 1'b0, hl);
                    set_pair(2'd2, 1'b0, v);
                end
                8'hc1, 8'hd1, 8'he1, 8'hf1: begin
                    set_pair(p, 1'b1, {ref_mem[sp + 16'd1], ref_mem[sp]});
                    sp = sp + 16'd2;
                end
                8'hc5, 8'hd5, 8'he5, 8'hf5: begin
                    v = get_pair(p, 1'b1);
                    model_write(sp - 16'd1, v[15:8]);
                    model_write(sp - 16'd2, v[7:0]);
                    sp = sp - 16'd2;
                end
                default: ;
            endcase
        end
    endfunction

    task automatic put_byte(input logic [15:0] a, input logic [7:0] d);
        ref_mem[a] = d;
        mem[a] <= d;
    endtask

    task automatic emit(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2);
        put_byte(mpc, b0);
        put_byte(mpc + 16'd1, b1);
        put_byte(mpc + 16'd2, b2);
        execute_model();
        n_insn++;
    endtask

    // Reloads a pair that no longer points into the data area.
    task automatic ensure_ptr(input logic [1:0] p);
        logic [15:0] v;
        logic [15:0] a;
        v = get_pair(p, 1'b0);
        a = rand_addr();
        if (v < 16'h8008 || v > 16'h8ff7)
            emit({2'b00, p, 4'b0001}, a[7:0], a[15:8]);
    endtask

    task automatic build_program();
        logic [2:0]  ra;
        logic [2:0]  rb;
        logic [1:0]  pp;
        logic [15:0] nn;
        logic [15:0] v;
        for (int i = 0; i < 65536; i++) begin
            ref_mem[i] = 8'h00;
            mem[i] <= 8'h00;
        end
        for (int i = 16'h8000; i < 16'h9000; i++) begin
            v = next_rand();
            put_byte(16'(i), v[7:0]);
        end
        for (int i = 0; i < 8; i++)
            r[i] = 8'h00;
        sp  = 16'h0000;
        mpc = 16'h0000;
        while (n_insn < 200) begin
            ra = pick_reg();
            rb = pick_reg();
            v  = next_rand();
            pp = v[1:0];
            nn = rand_addr();
            case (next_rand() % 12)
                0: emit({2'b00, ra, 3'b110}, v[9:2], 8'h00);
                1: emit({2'b01, ra, rb}, 8'h00, 8'h00);
                2: begin
                    ensure_ptr(2'd2);
                    emit({2'b01, ra, 3'b110}, 8'h00, 8'h00);
                end
                3: begin
                    ensure_ptr(2'd2);
                    emit({2'b01, 3'b110, ra}, 8'h00, 8'h00);
                end
                4: begin
                    ensure_ptr(2'd2);
                    emit(8'h36, v[9:2], 8'h00);
                end
                5: emit({2'b00, pp, 4'b0001}, nn[7:0], nn[15:8]);
                6: emit(v[2] ? 8'h32 : 8'h3a, nn[7:0], nn[15:8]);
                7: begin
                    ensure_ptr({1'b0, pp[0]});
                    emit({3'b000, pp[0], pp[1], 3'b010}, 8'h00, 8'h00);
                end
                8: emit(v[2] ? 8'h22 : 8'h2a, nn[7:0], nn[15:8]);
                9: begin
                    ensure_ptr(2'd2);
                    emit(8'hf9, 8'h00, 8'h00);
                end
                10: begin
                    ensure_ptr(2'd3);
                    emit({2'b11, pp, 1'b0, v[2], 2'b01}, 8'h00, 8'h00);
                end
                default: emit(v[2] ? 8'heb : nop_op(v[5:3]), 8'h00, 8'h00);
            endcase
        end
        // Final stores make every register visible in memory.
        emit(8'h22, 8'h00, 8'h8f);
        emit(8'heb, 8'h00, 8'h00);
        emit(8'h22, 8'h02, 8'h8f);
        emit(8'heb, 8'h00, 8'h00);
        emit(8'h32, 8'h04, 8'h8f);
        ensure_ptr(2'd3);
        emit(8'hc5, 8'h00, 8'h00);
        emit(8'hf5, 8'h00, 8'h00);
    endtask

    always @(posedge clk) begin
        if (!reset && write_mem) begin
            if (exp_addr.size() == 0) begin
                fail_run("DUT wrote memory where the model expects no write");
            end else begin
                check("addr", addr, exp_addr.pop_front());
                check("write_data", {8'h00, write_data}, {8'h00, exp_data.pop_front()});
            end
        end
        if (!reset && done)
            done_count <= done_count + 1;
    end

    initial begin
        wait (gen_done);
        #(n_insn * 8 * 4 + 100);
        fail_run("The instructions did not all retire before the timeout");
    end

    initial begin
        reset = 1'b1;
        build_program();
        gen_done = 1'b1;
        repeat (4) @(posedge clk);
        #0.5 reset = 1'b0;
        check("addr", addr, 16'h0000);
        check("read_mem", {15'h0, read_mem}, 16'h0001);
        check("write_mem", {15'h0, write_mem}, 16'h0000);
        wait (done_count >= n_insn);
        #0.5;
        // After the last retire the bus shows the address that follows the program.
        check("addr", addr, mpc);
        for (int i = 0; i < 65536; i++)
            check($sformatf("mem[%h]", i), {8'h00, mem[i]}, {8'h00, ref_mem[i]});
        if (exp_addr.size() != 0) begin
            fail_run("Expected memory writes were never seen");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== z80_core.f ====
source/z80_pkg.sv
source/instr_decoder.sv
source/insn_fetch.sv
source/register_file.sv
source/sequencer.sv
source/z80_core.sv
verification/z80_core_sva.sv
verification/z80_core_tb.sv

// ==== Makefile ====
SRCS := $(wildcard source/*.sv verification/*.sv)

all: run

obj_dir/Vz80_core_tb: z80_core.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
		--top-module z80_core_tb -f z80_core.f

run: obj_dir/Vz80_core_tb
	./obj_dir/Vz80_core_tb | grep "Simulation finished: PASS"

clean:
	rm -rf obj_dir

.PHONY: all run clean
